/* ctrl_top.f */
logic/uart_pkg.sv
logic/meas_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/frame_receiver.sv
logic/cmd_sequencer.sv
logic/freq_meter.sv
logic/reply_sender.sv
logic/ctrl_top.sv
verif/tb_clock_gen.sv
verif/ctrl_top_assertions.sv
verif/ctrl_top_tb.sv

/* verif/ctrl_top_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrl_top_tb;

    localparam int BIT_CYCLES   = uart_pkg::CLKS_PER_BIT;
    localparam int FRAME_CYCLES = 8 * 10 * BIT_CYCLES;
    localparam int REPLY_CYCLES = 9 * 10 * BIT_CYCLES;
    localparam int LED_WINDOW   = 50;
    // six frames, three replies with their gates, three error delays, plus half again
    localparam int TIMEOUT_CYCLES = (6 * FRAME_CYCLES
                                   + 3 * (REPLY_CYCLES + 2 * meas_pkg::GATE_CYCLES)
                                   + 3 * (meas_pkg::ERR_DELAY + LED_WINDOW)) * 3 / 2;
    // first reply byte trails the frame by a whole gate
    localparam int FIRST_WAIT = 4 * meas_pkg::GATE_CYCLES;

    // frame bytes as the host sends them
    localparam logic [7:0]  HEAD_OK  = 8'hA5;
    localparam logic [7:0]  HEAD_BAD = 8'h55;
    localparam logic [7:0]  TAIL_OK  = 8'hEC;
    localparam logic [47:0] CMD_FREQ_CODE = 48'd1;
    localparam logic [47:0] CMD_TUBE_CODE = 48'd2;

    logic I_sys_clk;
    logic I_rst_n;
    logic I_clk_fx;
    logic uart_rx;
    logic uart_tx;
    logic O_led;

    // fx source state
    int fx_div;
    int fx_phase;
    int cycle_cnt;

    tb_clock_gen #(.PERIOD_NS(4)) u_clk_gen (.clk(I_sys_clk));

    ctrl_top uut (
        .I_sys_clk,
        .I_rst_n,
        .I_clk_fx,
        .uart_rx,
        .uart_tx,
        .O_led
    );

    ////////////////////////////////////////
    // fx source and timeout
    ////////////////////////////////////////
    // fx period of fx_div system clocks
    always @(posedge I_sys_clk) begin
        if (fx_phase >= fx_div - 1) begin
            fx_phase <= 0;
        end else begin
            fx_phase <= fx_phase + 1;
        end
        I_clk_fx <= (fx_phase < fx_div / 2);
    end

    always @(posedge I_sys_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout, run went past %0d cycles", TIMEOUT_CYCLES);
            stop_with_fail();
        end
    end

    // any failed sequencer property ends the run
    always @(posedge I_sys_clk) begin
        if (uut.u_cmd_sequencer.u_seq_checks.assert_fail) begin
            $display("a sequencer assertion failed");
            stop_with_fail();
        end
    end

    ////////////////////////////////////////
    // checking helpers
    ////////////////////////////////////////
    task automatic stop_with_fail();
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_equal(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_with_fail();
        end
    endtask

    // line idle and led steady for a number of cycles
    task automatic hold_check(input int cycles, input logic led_exp);
        int i;
        for (i = 0; i < cycles; i++) begin
            @(posedge I_sys_clk);
            check_equal("uart_tx", uart_tx, 1'b1);
            check_equal("O_led", O_led, led_exp);
        end
    endtask

    ////////////////////////////////////////
    // uart host model
    ////////////////////////////////////////
    // start bit, data lsb first, stop bit
    task automatic send_byte(input logic [7:0] data);
        logic [9:0] bits;
        int         i;
        bits = {1'b1, data, 1'b0};
        for (i = 0; i < 10; i++) begin
            @(posedge I_sys_clk);
            uart_rx <= bits[i];
            repeat (BIT_CYCLES - 1) @(posedge I_sys_clk);
        end
    endtask

    // tail goes first, header last
    task automatic send_frame(input logic [7:0] head, input logic [47:0] cmd);
        logic [63:0] bits;
        int          k;
        bits = {head, cmd, TAIL_OK};
        for (k = 0; k < 8; k++) begin
            send_byte(bits[8 * k +: 8]);
        end
    endtask

    task automatic wait_start_bit(input int max_wait);
        int waited;
        waited = 0;
        while (uart_tx !== 1'b0 && waited < max_wait) begin
            @(posedge I_sys_clk);
            waited++;
        end
        if (uart_tx !== 1'b0) begin
            $display("no start bit on uart_tx within %0d cycles", max_wait);
            stop_with_fail();
        end
    endtask

    // samples each bit near its middle
    task automatic recv_byte(input int max_wait, output logic [7:0] data);
        int i;
        wait_start_bit(max_wait);
        repeat (BIT_CYCLES / 2) @(posedge I_sys_clk);
        check_equal("uart_tx start bit", uart_tx, 1'b0);
        for (i = 0; i < 8; i++) begin
            repeat (BIT_CYCLES) @(posedge I_sys_clk);
            data[i] = uart_tx;
        end
        repeat (BIT_CYCLES) @(posedge I_sys_clk);
        check_equal("uart_tx stop bit", uart_tx, 1'b1);
    endtask

    // sync byte, then eight result bytes lsb first
    task automatic recv_reply(output meas_pkg::meas_result_t res);
        logic [7:0]  data;
        logic [63:0] bits;
        int          k;
        recv_byte(FIRST_WAIT, data);
        check_equal("reply sync byte", data, uart_pkg::REPLY_SYNC);
        for (k = 0; k < 8; k++) begin
            recv_byte(3 * BIT_CYCLES, data);
            bits[8 * k +: 8] = data;
        end
        res = bits;
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////
    task automatic idle_after_reset();
        hold_check(200, 1'b1);
    endtask

    task automatic measure_freq(input int div);
        meas_pkg::meas_result_t res;
        fx_div <= div;
        // let the fx source settle on the new period
        repeat (4 * div) @(posedge I_sys_clk);
        send_frame(HEAD_OK, CMD_FREQ_CODE);
        check_equal("O_led after valid frame", O_led, 1'b1);
        recv_reply(res);
        // whole fx periods inside the gate
        check_equal("f0_cnt", res.f0_cnt, res.fx_cnt * div);
        check_equal("fx_cnt at least gate/div",
                    res.fx_cnt >= meas_pkg::GATE_CYCLES / div, 1'b1);
        // nothing after the ninth byte
        hold_check(20 * BIT_CYCLES, 1'b1);
    endtask

    task automatic reject_bad_header();
        int waited;
        send_frame(HEAD_BAD, CMD_FREQ_CODE);
        // counted from the start of the last stop bit
        waited = BIT_CYCLES - 1;
        while (O_led === 1'b1 && waited <= meas_pkg::ERR_DELAY + LED_WINDOW) begin
            @(posedge I_sys_clk);
            waited++;
            check_equal("uart_tx", uart_tx, 1'b1);
        end
        if (O_led !== 1'b0 || waited < meas_pkg::ERR_DELAY
                || waited > meas_pkg::ERR_DELAY + LED_WINDOW) begin
            $display("O_led missed its window, %0d cycles after the last stop bit", waited);
            stop_with_fail();
        end
    endtask

    // digital tube command is unknown now
    task automatic reject_tube_cmd();
        send_frame(HEAD_OK, CMD_TUBE_CODE);
        hold_check(meas_pkg::ERR_DELAY + LED_WINDOW, 1'b0);
    endtask

    initial begin
        I_rst_n   = 1'b0;
        uart_rx   = 1'b1;
        I_clk_fx  = 1'b0;
        fx_div    = 7;
        fx_phase  = 0;
        cycle_cnt = 0;
        repeat (8) @(posedge I_sys_clk);
        I_rst_n <= 1'b1;

        idle_after_reset();
        measure_freq(7);
        reject_bad_header();
        reject_tube_cmd();
        // recovery from the error state
        check_equal("O_led before recovery", O_led, 1'b0);
        measure_freq(7);
        measure_freq(5);

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/ctrl_top_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

// protocol checks on the command sequencer outputs
module ctrl_top_assertions (
    input logic I_sys_clk,
    input logic I_rst_n,
    input logic meas_start,
    input logic reply_start,
    input logic O_led
);

    // sticky flag, set by any failing property
    logic assert_fail;

    initial begin
        assert_fail = 1'b0;
    end

    ////////////////////////////////////////
    // single cycle pulses
    ////////////////////////////////////////
    meas_start_pulse: assert property (@(posedge I_sys_clk) disable iff (!I_rst_n)
        meas_start |=> !meas_start)
        else begin
            $error("meas_start held longer than one cycle");
            assert_fail = 1'b1;
        end

    reply_start_pulse: assert property (@(posedge I_sys_clk) disable iff (!I_rst_n)
        reply_start |=> !reply_start)
        else begin
            $error("reply_start held longer than one cycle");
            assert_fail = 1'b1;
        end

    // measure and reply never launched together
    starts_exclusive: assert property (@(posedge I_sys_clk) disable iff (!I_rst_n)
        !(meas_start && reply_start))
        else begin
            $error("meas_start and reply_start in the same cycle");
            assert_fail = 1'b1;
        end

    // led comes out of reset high
    led_high_after_reset: assert property (@(posedge I_sys_clk)
        $rose(I_rst_n) |-> O_led)
        else begin
            $error("O_led low in the first cycle after reset");
            assert_fail = 1'b1;
        end

endmodule

bind cmd_sequencer ctrl_top_assertions u_seq_checks (
    .I_sys_clk,
    .I_rst_n,
    .meas_start,
    .reply_start,
    .O_led
);

`default_nettype wire

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

// free running system clock for the testbench
module tb_clock_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);

    // half period per toggle
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* logic/ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrl_top (
    input  logic I_sys_clk,
    input  logic I_rst_n,
    input  logic I_clk_fx,
    input  logic uart_rx,
    output logic uart_tx,
    output logic O_led
);

    // receive path
    logic                   rx_valid;
    uart_pkg::uart_byte_t   rx_byte;
    logic                   frame_valid;
    uart_pkg::frame_t       frame;

    // measurement and reply path
    logic                   meas_start;
    logic                   meas_done;
    meas_pkg::meas_result_t meas_result;
    logic                   reply_start;
    meas_pkg::meas_result_t reply_result;
    logic                   reply_done;

    // transmit handshake
    logic                   tx_valid;
    uart_pkg::uart_byte_t   tx_byte;
    logic                   tx_ready;

    uart_rx u_uart_rx (.I_sys_clk, .I_rst_n, .uart_rx, .rx_valid, .rx_byte);

    frame_receiver u_frame_receiver (.I_sys_clk, .I_rst_n, .rx_valid, .rx_byte,
                                     .frame_valid, .frame);

    cmd_sequencer u_cmd_sequencer (.I_sys_clk, .I_rst_n, .frame_valid, .frame,
                                   .meas_start, .meas_done, .result(meas_result),
                                   .reply_start, .reply_result, .reply_done, .O_led);

    freq_meter u_freq_meter (.I_sys_clk, .I_rst_n, .I_clk_fx, .meas_start,
                             .meas_done, .result(meas_result));

    reply_sender u_reply_sender (.I_sys_clk, .I_rst_n, .reply_start, .reply_result,
                                 .tx_valid, .tx_byte, .tx_ready, .reply_done);

    uart_tx u_uart_tx (.I_sys_clk, .I_rst_n, .tx_valid, .tx_byte, .tx_ready, .uart_tx);

endmodule

`default_nettype wire

/* logic/reply_sender.sv */
`timescale 1ns/1ps
`default_nettype none

module reply_sender (
    input  logic                   I_sys_clk,
    input  logic                   I_rst_n,
    input  logic                   reply_start,
    input  meas_pkg::meas_result_t reply_result,
    output logic                   tx_valid,
    output uart_pkg::uart_byte_t   tx_byte,
    input  logic                   tx_ready,
    output logic                   reply_done
);

    typedef logic [$clog2(uart_pkg::REPLY_BYTES + 1)-1:0] left_cnt_t;

    left_cnt_t                                 bytes_left;
    logic                                      tx_accept;
    logic [$bits(meas_pkg::meas_result_t)-1:0] data_q;

    assign tx_accept = tx_valid & tx_ready;

    // handshake and byte count
    always_ff @(posedge I_sys_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            tx_valid   <= 1'b0;
            reply_done <= 1'b0;
            bytes_left <= '0;
        end else begin
            reply_done <= 1'b0;
            if (reply_start) begin
                tx_valid   <= 1'b1;
                bytes_left <= left_cnt_t'(uart_pkg::REPLY_BYTES);
            end else if (tx_accept) begin
                if (bytes_left == '0) begin
                    // last result byte taken
                    tx_valid   <= 1'b0;
                    reply_done <= 1'b1;
                end else begin
                    bytes_left <= bytes_left - 1'b1;
                end
            end
        end
    end

    // sync byte first, then the result lsb first
    always_ff @(posedge I_sys_clk) begin
        if (reply_start) begin
            tx_byte <= uart_pkg::REPLY_SYNC;
            data_q  <= reply_result;
        end else if (tx_accept) begin
            tx_byte <= data_q[7:0];
            data_q  <= data_q >> 8;
        end
    end

endmodule

`default_nettype wire

/* logic/freq_meter.sv */
`timescale 1ns/1ps
`default_nettype none

module freq_meter (
    input  logic                   I_sys_clk,
    input  logic                   I_rst_n,
    input  logic                   I_clk_fx,
    input  logic                   meas_start,
    output logic                   meas_done,
    output meas_pkg::meas_result_t result
);

    typedef enum logic [1:0] {FM_IDLE, FM_ARM, FM_GATE, FM_DONE} fm_state_t;

    fm_state_t      state_q;
    logic [2:0]     fx_sync;
    logic           fx_rise;
    logic           gate_full;
    meas_pkg::cnt_t gate_cnt;
    meas_pkg::cnt_t f0_cnt;
    meas_pkg::cnt_t fx_cnt;

    // fx into the system clock domain
    always_ff @(posedge I_sys_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            fx_sync <= '0;
        end else begin
            fx_sync <= {fx_sync[1:0], I_clk_fx};
        end
    end

    assign fx_rise   = fx_sync[1] & ~fx_sync[2];
    // minimum gate length reached
    assign gate_full = (gate_cnt == meas_pkg::cnt_t'(meas_pkg::GATE_CYCLES));

    ////////////////////////////////////////
    // gate control and counters
    ////////////////////////////////////////
    always_ff @(posedge I_sys_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            state_q  <= FM_IDLE;
            gate_cnt <= '0;
            f0_cnt   <= '0;
            fx_cnt   <= '0;
        end else begin
            case (state_q)
                FM_IDLE: begin
                    if (meas_start) begin
                        f0_cnt   <= '0;
                        fx_cnt   <= '0;
                        gate_cnt <= '0;
                        state_q  <= FM_ARM;
                    end
                end
                FM_ARM: begin
                    // gate opens on an fx edge
                    if (fx_rise) begin
                        state_q <= FM_GATE;
                    end
                end
                FM_GATE: begin
                    // closing cycle is counted too, so f0 spans whole fx periods
                    f0_cnt <= f0_cnt + 1'b1;
                    if (fx_rise) begin
                        fx_cnt <= fx_cnt + 1'b1;
                    end
                    if (!gate_full) begin
                        gate_cnt <= gate_cnt + 1'b1;
                    end else if (fx_rise) begin
                        state_q <= FM_DONE;
                    end
                end
                default: state_q <= FM_IDLE;
            endcase
        end
    end

    assign meas_done     = (state_q == FM_DONE);
    assign result.f0_cnt = f0_cnt;
    assign result.fx_cnt = fx_cnt;

endmodule

`default_nettype wire

/* logic/cmd_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_sequencer (
    input  logic                   I_sys_clk,
    input  logic                   I_rst_n,
    input  logic                   frame_valid,
    input  uart_pkg::frame_t       frame,
    output logic                   meas_start,
    input  logic                   meas_done,
    input  meas_pkg::meas_result_t result,
    output logic                   reply_start,
    output meas_pkg::meas_result_t reply_result,
    input  logic                   reply_done,
    output logic                   O_led
);

    typedef enum logic [1:0] {SQ_IDLE, SQ_MEASURE, SQ_REPLY, SQ_ERROR} sq_state_t;

    sq_state_t      state_q;
    meas_pkg::cnt_t err_cnt;
    logic           frame_ok;

    // header, tail and command all have to match
    assign frame_ok = (frame.head == uart_pkg::FRAME_HEAD)
                   && (frame.tail == uart_pkg::FRAME_TAIL)
                   && (frame.cmd  == meas_pkg::CMD_FREQ);

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    always_ff @(posedge I_sys_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            state_q     <= SQ_IDLE;
            err_cnt     <= '0;
            meas_start  <= 1'b0;
            reply_start <= 1'b0;
            O_led       <= 1'b1;
        end else begin
            meas_start  <= 1'b0;
            reply_start <= 1'b0;
            case (state_q)
                SQ_IDLE: begin
                    err_cnt <= '0;
                    if (frame_valid) begin
                        if (frame_ok) begin
                            meas_start <= 1'b1;
                            // accepted frame clears the error
                            O_led      <= 1'b1;
                            state_q    <= SQ_MEASURE;
                        end else begin
                            state_q <= SQ_ERROR;
                        end
                    end
                end
                SQ_MEASURE: begin
                    if (meas_done) begin
                        reply_start <= 1'b1;
                        state_q     <= SQ_REPLY;
                    end
                end
                SQ_REPLY: begin
                    if (reply_done) begin
                        state_q <= SQ_IDLE;
                    end
                end
                SQ_ERROR: begin
                    // led drops ERR_DELAY cycles after the frame strobe
                    if (err_cnt == meas_pkg::cnt_t'(meas_pkg::ERR_DELAY - 1)) begin
                        O_led   <= 1'b0;
                        state_q <= SQ_IDLE;
                    end else begin
                        err_cnt <= err_cnt + 1'b1;
                    end
                end
                default: state_q <= SQ_IDLE;
            endcase
        end
    end

    // result copy handed to the reply path
    always_ff @(posedge I_sys_clk) begin
        if (state_q == SQ_MEASURE && meas_done) begin
            reply_result <= result;
        end
    end

endmodule

`default_nettype wire

/* logic/frame_receiver.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_receiver (
    input  logic                 I_sys_clk,
    input  logic                 I_rst_n,
    input  logic                 rx_valid,
    input  uart_pkg::uart_byte_t rx_byte,
    output logic                 frame_valid,
    output uart_pkg::frame_t     frame
);

    typedef logic [$clog2(uart_pkg::FRAME_BYTES)-1:0] byte_cnt_t;

    byte_cnt_t                             byte_cnt;
    logic [$bits(uart_pkg::frame_t)-1:0]   frame_bits;

    // byte position and frame strobe
    always_ff @(posedge I_sys_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            byte_cnt    <= '0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= rx_valid && (byte_cnt == byte_cnt_t'(uart_pkg::FRAME_BYTES - 1));
            if (rx_valid) begin
                // wraps back to lane 0 after the header
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

    // byte k lands in lane k
    always_ff @(posedge I_sys_clk) begin
        if (rx_valid) begin
            if (byte_cnt == '0) begin
                frame_bits <= {{($bits(frame_bits) - 8){1'b0}}, rx_byte};
            end else begin
                frame_bits[byte_cnt * 8 +: 8] <= rx_byte;
            end
        end
    end

    assign frame = uart_pkg::frame_t'(frame_bits);

endmodule

`default_nettype wire

/* logic/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic                 I_sys_clk,
    input  logic                 I_rst_n,
    input  logic                 tx_valid,
    input  uart_pkg::uart_byte_t tx_byte,
    output logic                 tx_ready,
    output logic                 uart_tx
);

    typedef logic [$clog2(uart_pkg::CLKS_PER_BIT)-1:0] baud_cnt_t;

    logic       busy_q;
    logic       line_q;
    baud_cnt_t  baud_cnt;
    logic [3:0] bit_cnt;
    // stop bit above the data bits
    logic [8:0] shift_q;

    always_ff @(posedge I_sys_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            busy_q   <= 1'b0;
            line_q   <= 1'b1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!busy_q) begin
            if (tx_valid) begin
                // start bit goes out now
                busy_q   <= 1'b1;
                line_q   <= 1'b0;
                baud_cnt <= '0;
                bit_cnt  <= '0;
            end
        end else if (baud_cnt == baud_cnt_t'(uart_pkg::CLKS_PER_BIT - 1)) begin
            baud_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                // end of stop bit, line stays high
                busy_q <= 1'b0;
            end else begin
                line_q  <= shift_q[0];
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    // data shifter, loaded on accept
    always_ff @(posedge I_sys_clk) begin
        if (!busy_q && tx_valid) begin
            shift_q <= {1'b1, tx_byte};
        end else if (busy_q && baud_cnt == baud_cnt_t'(uart_pkg::CLKS_PER_BIT - 1)) begin
            shift_q <= {1'b1, shift_q[8:1]};
        end
    end

    assign tx_ready = ~busy_q;
    assign uart_tx  = line_q;

endmodule

`default_nettype wire

/* logic/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  logic                 I_sys_clk,
    input  logic                 I_rst_n,
    input  logic                 uart_rx,
    output logic                 rx_valid,
    output uart_pkg::uart_byte_t rx_byte
);

    typedef logic [$clog2(uart_pkg::CLKS_PER_BIT)-1:0] baud_cnt_t;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t            state_q;
    baud_cnt_t            baud_cnt;
    logic [2:0]           bit_idx;
    logic [2:0]           rx_sync;
    logic                 rx_bit;
    logic                 rx_fall;
    logic                 bit_end;
    uart_pkg::uart_byte_t shift_q;

    // three stage synchronizer, idles high
    always_ff @(posedge I_sys_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            rx_sync <= 3'b111;
        end else begin
            rx_sync <= {rx_sync[1:0], uart_rx};
        end
    end

    assign rx_bit  = rx_sync[1];
    // start bit edge
    assign rx_fall = rx_sync[2] & ~rx_sync[1];
    assign bit_end = (baud_cnt == baud_cnt_t'(uart_pkg::CLKS_PER_BIT - 1));

    always_ff @(posedge I_sys_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            state_q  <= RX_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state_q)
                RX_IDLE: begin
                    baud_cnt <= '0;
                    bit_idx  <= '0;
                    if (rx_fall) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    // half a bit to reach mid start bit
                    if (baud_cnt == baud_cnt_t'(uart_pkg::CLKS_PER_BIT / 2 - 1)) begin
                        baud_cnt <= '0;
                        // line back high means a glitch
                        state_q  <= rx_bit ? RX_IDLE : RX_DATA;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state_q <= RX_STOP;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        // framing error drops the byte
                        rx_valid <= rx_bit;
                        state_q  <= RX_IDLE;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge I_sys_clk) begin
        if (state_q == RX_DATA && bit_end) begin
            shift_q <= {rx_bit, shift_q[7:1]};
        end
    end

    assign rx_byte = shift_q;

endmodule

`default_nettype wire

/* logic/meas_pkg.sv */
`default_nettype none

////////////////////////////////////////
// commands and frequency measurement
////////////////////////////////////////
package meas_pkg;

    // only supported command code
    localparam logic [47:0] CMD_FREQ = 48'd1;

    // minimum gate length in system clocks
    localparam int GATE_CYCLES = 1024;

    // cycles from a rejected frame to led low
    localparam int ERR_DELAY = 50_000;

    typedef logic [31:0] cnt_t;

    // reference clock count in the high half
    // fx edge count in the low half, sent first
    typedef struct packed {
        cnt_t f0_cnt;
        cnt_t fx_cnt;
    } meas_result_t;

endpackage

`default_nettype wire

/* logic/uart_pkg.sv */
`default_nettype none

////////////////////////////////////////
// serial link and command frame
////////////////////////////////////////
package uart_pkg;

    // system clocks per serial bit, small value for simulation
    localparam int CLKS_PER_BIT = 16;

    // bytes per host frame and per reply payload
    localparam int FRAME_BYTES = 8;
    localparam int REPLY_BYTES = 8;

    typedef logic [7:0] uart_byte_t;

    // byte 7 is the header, byte 0 the tail
    typedef struct packed {
        uart_byte_t  head;
        logic [47:0] cmd;
        uart_byte_t  tail;
    } frame_t;

    localparam uart_byte_t FRAME_HEAD = 8'hA5;
    localparam uart_byte_t FRAME_TAIL = 8'hEC;
    // first byte of every reply
    localparam uart_byte_t REPLY_SYNC = 8'h5A;

endpackage

`default_nettype wire
